// File: aes_cfg_pkg.sv
//--------------------------------------------------------------------------
// AES-128 sizes, shared types and controller states
// Byte 0 of a state or key sits in bits [127:120], column-major order
//--------------------------------------------------------------------------
package aes_cfg_pkg;

  // Block and key geometry
  localparam int STATE_W = 128;
  localparam int WORD_W = 32;
  localparam int BYTE_W = 8;

  // AES-128 round count
  localparam int NUM_ROUNDS = 10;

  // Full state or one round key
  typedef logic [STATE_W-1:0] state_t;

  // One column or one key word
  typedef logic [WORD_W-1:0] word_t;

  typedef logic [BYTE_W-1:0] byte_t;

  // Wide enough for rounds 0 to NUM_ROUNDS-1
  typedef logic [$clog2(NUM_ROUNDS)-1:0] round_cnt_t;

  //--------------------------------------------------------------------------
  // Controller states
  //--------------------------------------------------------------------------
  // ctrl_idle  waits for req, loads block and key
  // ctrl_run   one inverse round per cycle
  // ctrl_done  ack held until req drops
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_run,
    ctrl_done
  } ctrl_state_e;

endpackage

// File: aes_gf_pkg.sv
//--------------------------------------------------------------------------
// GF(2^8) helpers for AES, S-box in composite field GF((2^4)^2)
// S-box works both ways, selected by the direction opcode
//--------------------------------------------------------------------------
package aes_gf_pkg;

  import aes_cfg_pkg::*;

  // S-box direction
  typedef enum logic {
    sbox_fwd,
    sbox_inv
  } sbox_dir_e;

  // Round constant of the last AES-128 round
  localparam byte_t RCON_LAST = 8'h36;

  // Isomorphic map and its inverse, row 7 in the top byte
  localparam logic [63:0] ISO_MAP = 64'hA0DE_ACAE_C69E_5243;
  localparam logic [63:0] ISO_INV = 64'hE244_6276_3E9E_3075;

  //--------------------------------------------------------------------------
  // Basic GF(2^8) steps
  //--------------------------------------------------------------------------
  function automatic byte_t gf_xtime(byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Inverse of xtime, walks rcon back one round
  function automatic byte_t gf_div2(byte_t b);
    logic [8:0] tmp;
    tmp = {1'b0, b} ^ (b[0] ? 9'h11b : 9'h000);
    return tmp[8:1];
  endfunction

  function automatic byte_t rotl8(byte_t x, int n);
    logic [15:0] d;
    d = {x, x} << n;
    return d[15:8];
  endfunction

  // Bit matrix times byte, each output bit is parity of a masked input
  function automatic byte_t gf_bitmat(byte_t x, logic [63:0] m);
    byte_t y;
    for (int i = 0; i < 8; i++) begin
      y[i] = ^(x & m[8*i +: 8]);
    end
    return y;
  endfunction

  //--------------------------------------------------------------------------
  // Subfield arithmetic
  //--------------------------------------------------------------------------
  function automatic logic [1:0] gf2_mul(logic [1:0] a, logic [1:0] b);
    logic [1:0] y;
    y[1] = (a[1] & b[1]) ^ (a[0] & b[1]) ^ (a[1] & b[0]);
    y[0] = (a[1] & b[1]) ^ (a[0] & b[0]);
    return y;
  endfunction

  // Karatsuba style, three GF(2^2) products
  function automatic logic [3:0] gf4_mul(logic [3:0] a, logic [3:0] b);
    logic [1:0] hh;
    logic [1:0] mm;
    logic [1:0] ll;
    logic [1:0] phi;
    hh = gf2_mul(a[3:2], b[3:2]);
    mm = gf2_mul(a[3:2] ^ a[1:0], b[3:2] ^ b[1:0]);
    ll = gf2_mul(a[1:0], b[1:0]);
    phi = {hh[1] ^ hh[0], hh[1]};
    return {mm ^ ll, phi ^ ll};
  endfunction

  function automatic logic [3:0] gf4_inv(logic [3:0] a);
    case (a)
      4'h0: return 4'h0;
      4'h1: return 4'h1;
      4'h2: return 4'h3;
      4'h3: return 4'h2;
      4'h4: return 4'hf;
      4'h5: return 4'hc;
      4'h6: return 4'h9;
      4'h7: return 4'hb;
      4'h8: return 4'ha;
      4'h9: return 4'h6;
      4'ha: return 4'h8;
      4'hb: return 4'h7;
      4'hc: return 4'h5;
      4'hd: return 4'he;
      4'he: return 4'hd;
      default: return 4'h4;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // Multiplicative inverse and S-box
  //--------------------------------------------------------------------------
  function automatic byte_t gf8_inv(byte_t x);
    byte_t      iso;
    logic [3:0] sq;
    logic [3:0] lam;
    logic [3:0] sum;
    logic [3:0] d_inv;
    iso = gf_bitmat(x, ISO_MAP);
    sq = {iso[7], iso[7] ^ iso[6], iso[6] ^ iso[5], iso[7] ^ iso[5] ^ iso[4]};
    // Square times lambda
    lam = {sq[2] ^ sq[0], ^sq, sq[3], sq[2]};
    sum = iso[7:4] ^ iso[3:0];
    d_inv = gf4_inv(lam ^ gf4_mul(sum, iso[3:0]));
    return gf_bitmat({gf4_mul(iso[7:4], d_inv), gf4_mul(sum, d_inv)}, ISO_INV);
  endfunction

  function automatic byte_t affine_fwd(byte_t x);
    return x ^ rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 3) ^ rotl8(x, 4) ^ 8'h63;
  endfunction

  function automatic byte_t affine_inv(byte_t x);
    return rotl8(x, 1) ^ rotl8(x, 3) ^ rotl8(x, 6) ^ 8'h05;
  endfunction

  // Shared inverter, affine step before it or after it
  function automatic byte_t sbox(byte_t x, sbox_dir_e dir);
    byte_t inv;
    inv = gf8_inv((dir == sbox_inv) ? affine_inv(x) : x);
    return (dir == sbox_fwd) ? affine_fwd(inv) : inv;
  endfunction

  //--------------------------------------------------------------------------
  // InvMixColumns on one column, matrix rows {0e 0b 0d 09} rotated
  //--------------------------------------------------------------------------
  function automatic word_t inv_mix_column(word_t col);
    byte_t a  [4];
    byte_t x2 [4];
    byte_t x4 [4];
    byte_t x8 [4];
    byte_t m9 [4];
    byte_t mb [4];
    byte_t md [4];
    byte_t me [4];
    for (int i = 0; i < 4; i++) begin
      a[i] = col[WORD_W-1-BYTE_W*i -: BYTE_W];
      x2[i] = gf_xtime(a[i]);
      x4[i] = gf_xtime(x2[i]);
      x8[i] = gf_xtime(x4[i]);
      m9[i] = x8[i] ^ a[i];
      mb[i] = x8[i] ^ x2[i] ^ a[i];
      md[i] = x8[i] ^ x4[i] ^ a[i];
      me[i] = x8[i] ^ x4[i] ^ x2[i];
    end
    return {me[0] ^ mb[1] ^ md[2] ^ m9[3],
            m9[0] ^ me[1] ^ mb[2] ^ md[3],
            md[0] ^ m9[1] ^ me[2] ^ mb[3],
            mb[0] ^ md[1] ^ m9[2] ^ me[3]};
  endfunction

endpackage

// File: aes_inv_key_sched.sv
//--------------------------------------------------------------------------
// On-the-fly inverse AES-128 key expansion, one round key back per step
// key_prev is combinational; it shows key_last while key_load is high
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_inv_key_sched (
  input  logic                clk_sys,
  input  logic                rst_n,
  input  aes_cfg_pkg::state_t key_last,
  input  logic                key_load,
  input  logic                key_step,
  output aes_cfg_pkg::state_t key_prev
);

  import aes_cfg_pkg::*;
  import aes_gf_pkg::*;

  localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

  state_t key_q;
  byte_t  rcon_q;

  // Words of the current round key
  word_t w0;
  word_t w1;
  word_t w2;
  word_t w3;

  // Words of the previous round key
  word_t p0;
  word_t p1;
  word_t p2;
  word_t p3;

  word_t rot_w;
  word_t sub_w;

  assign {w0, w1, w2, w3} = key_q;

  // Undo the chained XOR of the forward expansion
  assign p3 = w3 ^ w2;
  assign p2 = w2 ^ w1;
  assign p1 = w1 ^ w0;

  // RotWord then SubWord of the recovered last word
  assign rot_w = {p3[WORD_W-BYTE_W-1:0], p3[WORD_W-1 -: BYTE_W]};

  always_comb begin
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      sub_w[BYTE_W*b +: BYTE_W] = sbox(rot_w[BYTE_W*b +: BYTE_W], sbox_fwd);
    end
  end

  assign p0 = w0 ^ sub_w ^ {rcon_q, {(WORD_W-BYTE_W){1'b0}}};

  // Bypass so the controller sees key 10 on the load edge
  assign key_prev = key_load ? key_last : {p0, p1, p2, p3};

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      rcon_q <= RCON_LAST;
    end else if (key_load) begin
      rcon_q <= RCON_LAST;
    end else if (key_step) begin
      rcon_q <= gf_div2(rcon_q);
    end
  end

  always_ff @(posedge clk_sys) begin
    if (key_load || key_step) begin
      key_q <= key_prev;
    end
  end

endmodule

// File: aes_inv_round.sv
//--------------------------------------------------------------------------
// One inverse round without AddRoundKey, purely combinational
// InvMixColumns of the previous round is done here, skipped on the first
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_inv_round (
  input  aes_cfg_pkg::state_t state,
  input  logic                first_round,
  output aes_cfg_pkg::state_t round_out
);

  import aes_cfg_pkg::*;
  import aes_gf_pkg::*;

  localparam int NUM_COLS = STATE_W / WORD_W;
  localparam int NUM_ROWS = WORD_W / BYTE_W;

  state_t mixed;
  state_t shifted;

  //--------------------------------------------------------------------------
  // InvMixColumns, deferred from the round before
  //--------------------------------------------------------------------------
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      if (first_round) begin
        mixed[STATE_W-1-WORD_W*c -: WORD_W] = state[STATE_W-1-WORD_W*c -: WORD_W];
      end else begin
        mixed[STATE_W-1-WORD_W*c -: WORD_W] =
          inv_mix_column(state[STATE_W-1-WORD_W*c -: WORD_W]);
      end
    end
  end

  //--------------------------------------------------------------------------
  // InvShiftRows
  //--------------------------------------------------------------------------
  // Row r moves right by r, so out[r][c] takes in[r][c-r]
  always_comb begin
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        shifted[STATE_W-1-BYTE_W*(NUM_ROWS*c+r) -: BYTE_W] =
          mixed[STATE_W-1-BYTE_W*(NUM_ROWS*((c-r+NUM_COLS)%NUM_COLS)+r) -: BYTE_W];
      end
    end
  end

  //--------------------------------------------------------------------------
  // InvSubBytes
  //--------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_COLS*NUM_ROWS; i++) begin
      round_out[BYTE_W*i +: BYTE_W] = sbox(shifted[BYTE_W*i +: BYTE_W], sbox_inv);
    end
  end

endmodule

// File: aes_inv_control.sv
//--------------------------------------------------------------------------
// Four-phase req/ack control, round counter and the state register
// Host holds cipher_text and key_last stable from req until ack rises
// plain_text is undefined until the first ack after reset
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_inv_control (
  input  logic                clk_sys,
  input  logic                rst_n,
  input  logic                req,
  input  aes_cfg_pkg::state_t cipher_text,
  input  aes_cfg_pkg::state_t key_prev,
  input  aes_cfg_pkg::state_t round_out,
  output logic                ack,
  output aes_cfg_pkg::state_t plain_text,
  output aes_cfg_pkg::state_t state,
  output logic                first_round,
  output logic                key_load,
  output logic                key_step
);

  import aes_cfg_pkg::*;

  ctrl_state_e ctrl_q;
  ctrl_state_e ctrl_d;
  round_cnt_t  round_q;
  state_t      data_q;
  logic        last_round;

  assign last_round = (round_q == round_cnt_t'(NUM_ROUNDS - 1));

  //--------------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------------
  always_comb begin
    ctrl_d = ctrl_q;
    case (ctrl_q)
      ctrl_idle: begin
        if (req) begin
          ctrl_d = ctrl_run;
        end
      end
      ctrl_run: begin
        if (last_round) begin
          ctrl_d = ctrl_done;
        end
      end
      ctrl_done: begin
        // Hold the result until the host lets go of req
        if (!req) begin
          ctrl_d = ctrl_idle;
        end
      end
      default: ctrl_d = ctrl_idle;
    endcase
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= ctrl_idle;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  // Round index within the run phase
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      round_q <= '0;
    end else if (key_load) begin
      round_q <= '0;
    end else if (key_step) begin
      round_q <= round_q + 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // State register with AddRoundKey
  //--------------------------------------------------------------------------
  // key_prev carries key_last during the load cycle
  always_ff @(posedge clk_sys) begin
    if (key_load) begin
      data_q <= cipher_text ^ key_prev;
    end else if (key_step) begin
      data_q <= round_out ^ key_prev;
    end
  end

  assign key_load = (ctrl_q == ctrl_idle) && req;
  assign key_step = (ctrl_q == ctrl_run);

  // No InvMixColumns before the first round
  assign first_round = key_step && (round_q == '0);

  assign state = data_q;
  assign plain_text = data_q;
  assign ack = (ctrl_q == ctrl_done);

endmodule

// File: aes_inv_top.sv
//--------------------------------------------------------------------------
// Iterative AES-128 decryption core, one block at a time
// key_last is round key 10; ack follows the tenth round edge
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module aes_inv_top (
  input  logic                clk_sys,
  input  logic                rst_n,
  input  logic                req,
  input  aes_cfg_pkg::state_t cipher_text,
  input  aes_cfg_pkg::state_t key_last,
  output logic                ack,
  output aes_cfg_pkg::state_t plain_text
);

  import aes_cfg_pkg::*;

  logic   key_load;
  logic   key_step;
  logic   first_round;
  state_t key_prev;
  state_t state;
  state_t round_out;

  aes_inv_control u_control (
    .clk_sys     (clk_sys),
    .rst_n       (rst_n),
    .req         (req),
    .cipher_text (cipher_text),
    .key_prev    (key_prev),
    .round_out   (round_out),
    .ack         (ack),
    .plain_text  (plain_text),
    .state       (state),
    .first_round (first_round),
    .key_load    (key_load),
    .key_step    (key_step)
  );

  aes_inv_round u_round (
    .state       (state),
    .first_round (first_round),
    .round_out   (round_out)
  );

  // Walks the key schedule from round 10 back to round 0
  aes_inv_key_sched u_key_sched (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .key_last (key_last),
    .key_load (key_load),
    .key_step (key_step),
    .key_prev (key_prev)
  );

endmodule

// File: tb_aes_model.svh
//--------------------------------------------------------------------------
// Software AES-128 reference (S-box, key expansion, forward cipher) and LFSR
// Included inside the testbench module; build_sbox must run before use
// Byte 0 sits in bits [127:120], column-major like the DUT
//--------------------------------------------------------------------------
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h96a6_6508;
// x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
localparam logic [7:0]  AFFINE_C  = 8'h63;

logic [31:0]  lfsr_q;
logic [7:0]   sbox_tab [256];
logic [127:0] round_keys [11];

//--------------------------------------------------------------------------
// Random source
//--------------------------------------------------------------------------
function automatic logic lfsr_bit();
  logic b;
  b = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (b) begin
    lfsr_q = lfsr_q ^ LFSR_TAPS;
  end
  return b;
endfunction

// One LFSR step per bit, first bit ends up most significant
function automatic logic [127:0] rand_bits(int n);
  logic [127:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[126:0], lfsr_bit()};
  end
  return v;
endfunction

//--------------------------------------------------------------------------
// Field arithmetic and S-box table
//--------------------------------------------------------------------------
// Shift-and-add multiply modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gmul(logic [7:0] a, logic [7:0] b);
  logic [7:0] p;
  logic [7:0] aa;
  p = 8'h00;
  aa = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ aa;
    end
    aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Inverse by exhaustive search, then the FIPS-197 affine map
function automatic void build_sbox();
  logic [7:0] inv;
  logic [7:0] s;
  for (int x = 0; x < 256; x++) begin
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (gmul(8'(x), 8'(y)) == 8'h01) begin
        inv = 8'(y);
      end
    end
    for (int i = 0; i < 8; i++) begin
      s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8]
             ^ AFFINE_C[i];
    end
    sbox_tab[x] = s;
  end
endfunction

function automatic logic [31:0] sub_word(logic [31:0] w);
  return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
endfunction

//--------------------------------------------------------------------------
// Forward key expansion and cipher
//--------------------------------------------------------------------------
function automatic void expand_key(logic [127:0] key);
  logic [31:0] w [44];
  logic [31:0] t;
  logic [7:0]  rc;
  rc = 8'h01;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127-32*i -: 32];
  end
  for (int i = 4; i < 44; i++) begin
    t = w[i-1];
    if (i % 4 == 0) begin
      t = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
      rc = gmul(rc, 8'h02);
    end
    w[i] = w[i-4] ^ t;
  end
  for (int r = 0; r < 11; r++) begin
    round_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
endfunction

// Uses round_keys from the last expand_key call
function automatic logic [127:0] encrypt_block(logic [127:0] pt);
  logic [7:0]   s [16];
  logic [7:0]   t [16];
  logic [127:0] blk;
  blk = pt ^ round_keys[0];
  for (int r = 1; r <= 10; r++) begin
    for (int i = 0; i < 16; i++) begin
      s[i] = sbox_tab[blk[127-8*i -: 8]];
    end
    // ShiftRows, row rw moves left by rw
    for (int c = 0; c < 4; c++) begin
      for (int rw = 0; rw < 4; rw++) begin
        t[4*c+rw] = s[4*((c+rw)%4)+rw];
      end
    end
    for (int c = 0; c < 4; c++) begin
      for (int i = 0; i < 4; i++) begin
        if (r != 10) begin
          s[4*c+i] = gmul(t[4*c+i], 8'h02) ^ gmul(t[4*c+(i+1)%4], 8'h03)
                     ^ t[4*c+(i+2)%4] ^ t[4*c+(i+3)%4];
        end else begin
          s[4*c+i] = t[4*c+i];
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      blk[127-8*i -: 8] = s[i];
    end
    blk = blk ^ round_keys[r];
  end
  return blk;
endfunction

`endif

// File: tb_aes_inv_top.sv
//--------------------------------------------------------------------------
// Testbench for the AES-128 decryption core with a four-phase req/ack host
// Inputs change on the falling edge, outputs are sampled there too
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_aes_inv_top;

  localparam int TIMEOUT_CYC = 100;
  // Load edge plus ten round edges
  localparam int ACK_EDGES = 11;
  localparam int NUM_RANDOM = 30;

  // FIPS-197 appendix C.1
  localparam logic [127:0] FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] FIPS_K10 = 128'h13111d7fe3944a17f307a78b4d2b30c5;
  localparam logic [127:0] FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic         clk_sys;
  logic         rst_n;
  logic         req;
  logic [127:0] cipher_text;
  logic [127:0] key_last;
  logic         ack;
  logic [127:0] plain_text;

  int err_cnt;
  int test_cnt;
  int fail_cnt;

  `include "tb_aes_model.svh"

  aes_inv_top UUT (
    .clk_sys     (clk_sys),
    .rst_n       (rst_n),
    .req         (req),
    .cipher_text (cipher_text),
    .key_last    (key_last),
    .ack         (ack),
    .plain_text  (plain_text)
  );

  always #5 clk_sys = ~clk_sys;

  task automatic close_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) begin
      fail_cnt++;
      $display("test %0d %s: failed", test_cnt, name);
    end else begin
      $display("test %0d %s: passed", test_cnt, name);
    end
  endtask

  task automatic check_idle();
    int errs_before;
    errs_before = err_cnt;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_sys);
      if (ack !== 1'b0) begin
        $display("** Error at %0t: ack = %b, expected 0", $time, ack);
        err_cnt++;
      end
    end
    close_test("idle after reset", errs_before);
  endtask

  //--------------------------------------------------------------------------
  // One full handshake with hold extra cycles of req after ack
  //--------------------------------------------------------------------------
  task automatic decrypt_check(input logic [127:0] k10, input logic [127:0] ct,
                               input logic [127:0] exp_pt, input int hold,
                               input string name);
    int           errs_before;
    int           wait_cyc;
    int           edges;
    errs_before = err_cnt;
    wait_cyc = 0;
    while (ack !== 1'b0 && wait_cyc < TIMEOUT_CYC) begin
      @(negedge clk_sys);
      wait_cyc++;
    end
    if (ack !== 1'b0) begin
      $display("Timeout: ack did not return low before a new request at %0t", $time);
      err_cnt++;
    end else begin
      req = 1'b1;
      cipher_text = ct;
      key_last = k10;
      edges = 0;
      do begin
        @(negedge clk_sys);
        edges++;
      end while (ack !== 1'b1 && edges < TIMEOUT_CYC);
      if (ack !== 1'b1) begin
        $display("Timeout: ack never rose after req at %0t", $time);
        err_cnt++;
      end else begin
        if (edges != ACK_EDGES) begin
          $display("** Error at %0t: edges to ack = %0d, expected %0d", $time, edges, ACK_EDGES);
          err_cnt++;
        end
        if (plain_text !== exp_pt) begin
          $display("** Error at %0t: plain_text = %h, expected %h", $time, plain_text, exp_pt);
          err_cnt++;
        end
        // Result must not move under back-pressure
        for (int i = 0; i < hold; i++) begin
          @(negedge clk_sys);
          if (ack !== 1'b1) begin
            $display("** Error at %0t: ack = %b, expected 1", $time, ack);
            err_cnt++;
          end
          if (plain_text !== exp_pt) begin
            $display("** Error at %0t: plain_text = %h, expected %h", $time, plain_text, exp_pt);
            err_cnt++;
          end
        end
      end
      req = 1'b0;
      @(negedge clk_sys);
      if (ack !== 1'b0) begin
        $display("** Error at %0t: ack = %b, expected 0", $time, ack);
        err_cnt++;
      end
    end
    close_test(name, errs_before);
  endtask

  initial begin
    logic [127:0] key;
    logic [127:0] pt;
    logic [127:0] ct;
    logic [127:0] rnd;
    clk_sys = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    cipher_text = '0;
    key_last = '0;
    err_cnt = 0;
    test_cnt = 0;
    fail_cnt = 0;
    lfsr_q = LFSR_SEED;
    build_sbox();
    repeat (2) @(negedge clk_sys);
    rst_n = 1'b1;

    check_idle();

    // Model must agree with the published vector before it is trusted
    expand_key(FIPS_KEY);
    if (round_keys[10] != FIPS_K10 || encrypt_block(FIPS_PT) != FIPS_CT) begin
      $display("Reference model does not reproduce the FIPS-197 vector");
      err_cnt++;
    end
    decrypt_check(FIPS_K10, FIPS_CT, FIPS_PT, 0, "FIPS-197 vector");

    // Random blocks back to back with a new key each time
    for (int n = 0; n < NUM_RANDOM; n++) begin
      key = rand_bits(128);
      pt = rand_bits(128);
      rnd = rand_bits(3);
      expand_key(key);
      ct = encrypt_block(pt);
      decrypt_check(round_keys[10], ct, pt, int'(rnd[2:0]), "random block");
    end

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
aes_cfg_pkg.sv
aes_gf_pkg.sv
aes_inv_key_sched.sv
aes_inv_round.sv
aes_inv_control.sv
aes_inv_top.sv
tb_aes_inv_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_aes_inv_top \
  -f verilog.f -o tb_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
